/* sram_pkg.sv */
/*
 * shared scratchpad memory definitions
 * widths, RAM request/response structs and the AXI front-end state
 */
`default_nettype none

package sram_pkg;

	localparam int MEM_AW = 10;  // 1024 words
	localparam int DATA_W = 32;
	localparam int AXI_AW = 16;  // byte address from the host
	localparam int STRB_W = 4;   // one enable per byte lane
	localparam int RD_LAT = 2;   // cycles from request edge to data

	typedef logic [MEM_AW-1:0] word_addr_t;
	typedef logic [AXI_AW-1:0] axi_addr_t;
	typedef logic [DATA_W-1:0] data_t;
	typedef logic [STRB_W-1:0] strb_t;
	typedef logic [1:0]        resp_t;

	localparam resp_t RESP_OKAY   = 2'b00;
	localparam resp_t RESP_SLVERR = 2'b10;

	// port A request of 48 bits
	typedef struct packed {
		logic       valid;
		logic       we;
		word_addr_t addr;
		data_t      wdata;
		strb_t      be;
	} mem_req_t;

	typedef struct packed {
		logic  valid;  // one cycle completion pulse
		data_t rdata;
	} mem_rsp_t;

	// read-only readout port request
	typedef struct packed {
		logic       en;
		word_addr_t addr;
	} rd_req_t;

	typedef enum logic [2:0] {IDLE, REQ, WAIT, BRESP, RRESP} port_state_e;

endpackage

`default_nettype wire

/* dpsram.sv */
/*
 * dual-port synchronous RAM, inputs registered one cycle
 * port A read/write with byte enables, port B read only
 */
`timescale 1ns/1ps
`default_nettype none

module dpsram (
	input  logic               clk_a,
	input  logic               rst_n,
	input  sram_pkg::mem_req_t a_req,
	output sram_pkg::data_t    a_rdata,
	input  sram_pkg::rd_req_t  b_req,
	output sram_pkg::data_t    b_rdata,
	output logic               b_valid
);
	import sram_pkg::*;

	data_t      mem [0:(2**MEM_AW)-1];
	logic       a_vld_q, b_en_q;      // registered enables
	logic       a_we_q;
	word_addr_t a_addr_q, b_addr_q;
	data_t      a_wdata_q;
	strb_t      a_be_q;

	always_ff @(posedge clk_a or negedge rst_n) begin
		if (!rst_n) begin
			a_vld_q <= 1'b0;
			b_en_q  <= 1'b0;
			b_valid <= 1'b0;
		end else begin
			a_vld_q <= a_req.valid;
			b_en_q  <= b_req.en;
			b_valid <= b_en_q;  // follows data out of port B
		end
	end

	// input stage for the payload only
	always_ff @(posedge clk_a) begin
		a_we_q    <= a_req.we;
		a_addr_q  <= a_req.addr;
		a_wdata_q <= a_req.wdata;
		a_be_q    <= a_req.be;
		b_addr_q  <= b_req.addr;
	end

	// port A writes the enabled lanes and reads the word before the write
	always_ff @(posedge clk_a) begin
		if (a_vld_q) begin
			if (a_we_q) begin
				for (int i = 0; i < STRB_W; i++)
					if (a_be_q[i]) mem[a_addr_q][i*8 +: 8] <= a_wdata_q[i*8 +: 8];
			end
			a_rdata <= mem[a_addr_q];
		end
	end

	always_ff @(posedge clk_a) begin
		if (b_en_q) b_rdata <= mem[b_addr_q];  // independent of port A
	end

	// a write with no lanes means the front end lost the strobes
	a_write_has_be: assert property (@(posedge clk_a) disable iff (!rst_n)
		a_vld_q && a_we_q |-> a_be_q != '0);

endmodule

`default_nettype wire

/* axil_mem_port.sv */
/*
 * AXI4-Lite slave front end, one transaction at a time
 * checks the 4 KiB window, issues a RAM request, returns B or R
 */
`timescale 1ns/1ps
`default_nettype none

module axil_mem_port (
	input  logic                clk_a,
	input  logic                rst_n,
	input  logic                awvalid, wvalid, bready, arvalid, rready,
	output logic                awready, wready, bvalid, arready, rvalid,
	input  sram_pkg::axi_addr_t awaddr, araddr,
	input  sram_pkg::data_t     wdata,
	input  sram_pkg::strb_t     wstrb,
	output sram_pkg::resp_t     bresp, rresp,
	output sram_pkg::data_t     rdata,
	output sram_pkg::mem_req_t  req,
	input  logic                gnt,
	input  sram_pkg::mem_rsp_t  rsp
);
	import sram_pkg::*;

	port_state_e state, state_nxt;
	logic        aw_go, ar_go;          // handshake this cycle
	logic        aw_in_win, ar_in_win;
	logic        we_q;
	word_addr_t  addr_q;
	data_t       wdata_q;
	strb_t       be_q;
	resp_t       resp_q;                // shared by B and R
	data_t       rdata_q;

	// write wins when both channels are pending
	assign aw_go   = (state == IDLE) && awvalid && wvalid;
	assign ar_go   = (state == IDLE) && arvalid && !(awvalid && wvalid);
	assign awready = aw_go;
	assign wready  = aw_go;
	assign arready = ar_go;

	// upper bits above word index and 2 byte offset bits must be zero
	assign aw_in_win = (awaddr[AXI_AW-1:MEM_AW+2] == '0);
	assign ar_in_win = (araddr[AXI_AW-1:MEM_AW+2] == '0);

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (aw_go)
					state_nxt = aw_in_win ? REQ : BRESP;  // SLVERR skips memory
				else if (ar_go)
					state_nxt = ar_in_win ? REQ : RRESP;
			end
			REQ:     if (gnt) state_nxt = WAIT;       // held until arbiter takes it
			WAIT:    if (rsp.valid) state_nxt = we_q ? BRESP : RRESP;
			BRESP:   if (bready) state_nxt = IDLE;
			RRESP:   if (rready) state_nxt = IDLE;
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk_a or negedge rst_n) begin
		if (!rst_n) state <= IDLE;
		else        state <= state_nxt;
	end

	// transaction capture and response payload
	always_ff @(posedge clk_a) begin
		if (aw_go) begin
			we_q    <= 1'b1;
			addr_q  <= awaddr[MEM_AW+1:2];  // byte to word address
			wdata_q <= wdata;
			be_q    <= wstrb;
			resp_q  <= aw_in_win ? RESP_OKAY : RESP_SLVERR;
		end else if (ar_go) begin
			we_q    <= 1'b0;
			addr_q  <= araddr[MEM_AW+1:2];
			be_q    <= '0;
			resp_q  <= ar_in_win ? RESP_OKAY : RESP_SLVERR;
			rdata_q <= '0;  // returned as is on SLVERR
		end
		if ((state == WAIT) && rsp.valid && !we_q)
			rdata_q <= rsp.rdata;
	end

	always_comb begin
		req.valid = (state == REQ);
		req.we    = we_q;
		req.addr  = addr_q;
		req.wdata = wdata_q;
		req.be    = be_q;
	end

	assign bvalid = (state == BRESP);
	assign rvalid = (state == RRESP);
	assign bresp  = resp_q;
	assign rresp  = resp_q;
	assign rdata  = rdata_q;

	one_resp_channel: assert property (@(posedge clk_a) disable iff (!rst_n)
		!(bvalid && rvalid));

	// response held under back-pressure
	b_stable: assert property (@(posedge clk_a) disable iff (!rst_n)
		bvalid && !bready |=> bvalid && $stable(bresp));

	r_stable: assert property (@(posedge clk_a) disable iff (!rst_n)
		rvalid && !rready |=> rvalid && $stable(rresp) && $stable(rdata));

endmodule

`default_nettype wire

/* mem_arbiter.sv */
/*
 * round-robin arbiter of two front ends onto RAM port A
 * owner pipeline routes completions and read data back
 */
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
	input  logic               clk_a,
	input  logic               rst_n,
	input  sram_pkg::mem_req_t req0,
	input  sram_pkg::mem_req_t req1,
	output logic               gnt0,
	output logic               gnt1,
	output sram_pkg::mem_rsp_t rsp0,
	output sram_pkg::mem_rsp_t rsp1,
	output sram_pkg::mem_req_t ram_req,
	input  sram_pkg::data_t    ram_rdata
);
	import sram_pkg::*;

	logic              last_gnt;  // 1 = port 1 had the last grant
	logic [RD_LAT-1:0] own_vld;   // access in flight per stage
	logic [RD_LAT-1:0] own_id;    // which port owns it

	// on a tie the port not granted last wins
	assign gnt0 = req0.valid && (!req1.valid || last_gnt);
	assign gnt1 = req1.valid && (!req0.valid || !last_gnt);

	always_comb begin
		ram_req       = gnt1 ? req1 : req0;
		ram_req.valid = gnt0 | gnt1;
	end

	always_ff @(posedge clk_a or negedge rst_n) begin
		if (!rst_n) begin
			last_gnt <= 1'b1;  // port 0 favoured first
			own_vld  <= '0;
			own_id   <= '0;
		end else begin
			if (gnt0 | gnt1) last_gnt <= gnt1;
			own_vld <= {own_vld[RD_LAT-2:0], gnt0 | gnt1};
			own_id  <= {own_id[RD_LAT-2:0], gnt1};
		end
	end

	// last stage lines up with RAM data
	always_comb begin
		rsp0.valid = own_vld[RD_LAT-1] && !own_id[RD_LAT-1];
		rsp0.rdata = ram_rdata;
		rsp1.valid = own_vld[RD_LAT-1] && own_id[RD_LAT-1];
		rsp1.rdata = ram_rdata;
	end

	gnt_legal: assert property (@(posedge clk_a) disable iff (!rst_n)
		!(gnt0 && gnt1) && (!gnt0 || req0.valid) && (!gnt1 || req1.valid));

endmodule

`default_nettype wire

/* shared_sram_top.sv */
/*
 * shared scratchpad top, two AXI4-Lite hosts on RAM port A
 * through the arbiter, fixed-latency readout on port B
 */
`timescale 1ns/1ps
`default_nettype none

module shared_sram_top (
	input  logic                clk_a,
	input  logic                rst_n,
	// host 0
	input  logic                s0_awvalid, s0_wvalid, s0_bready, s0_arvalid, s0_rready,
	output logic                s0_awready, s0_wready, s0_bvalid, s0_arready, s0_rvalid,
	input  sram_pkg::axi_addr_t s0_awaddr, s0_araddr,
	input  sram_pkg::data_t     s0_wdata,
	input  sram_pkg::strb_t     s0_wstrb,
	output sram_pkg::resp_t     s0_bresp, s0_rresp,
	output sram_pkg::data_t     s0_rdata,
	// host 1
	input  logic                s1_awvalid, s1_wvalid, s1_bready, s1_arvalid, s1_rready,
	output logic                s1_awready, s1_wready, s1_bvalid, s1_arready, s1_rvalid,
	input  sram_pkg::axi_addr_t s1_awaddr, s1_araddr,
	input  sram_pkg::data_t     s1_wdata,
	input  sram_pkg::strb_t     s1_wstrb,
	output sram_pkg::resp_t     s1_bresp, s1_rresp,
	output sram_pkg::data_t     s1_rdata,
	// readout
	input  sram_pkg::rd_req_t   rd_req,
	output sram_pkg::data_t     rd_data,
	output logic                rd_valid
);
	import sram_pkg::*;

	mem_req_t req0, req1, ram_a_req;
	mem_rsp_t rsp0, rsp1;
	logic     gnt0, gnt1;
	data_t    ram_a_rdata;

	axil_mem_port u_port0 (
		.clk_a(clk_a), .rst_n(rst_n),
		.awvalid(s0_awvalid), .awready(s0_awready), .awaddr(s0_awaddr),
		.wvalid(s0_wvalid), .wready(s0_wready), .wdata(s0_wdata), .wstrb(s0_wstrb),
		.bvalid(s0_bvalid), .bready(s0_bready), .bresp(s0_bresp),
		.arvalid(s0_arvalid), .arready(s0_arready), .araddr(s0_araddr),
		.rvalid(s0_rvalid), .rready(s0_rready), .rdata(s0_rdata), .rresp(s0_rresp),
		.req(req0), .gnt(gnt0), .rsp(rsp0)
	);

	axil_mem_port u_port1 (
		.clk_a(clk_a), .rst_n(rst_n),
		.awvalid(s1_awvalid), .awready(s1_awready), .awaddr(s1_awaddr),
		.wvalid(s1_wvalid), .wready(s1_wready), .wdata(s1_wdata), .wstrb(s1_wstrb),
		.bvalid(s1_bvalid), .bready(s1_bready), .bresp(s1_bresp),
		.arvalid(s1_arvalid), .arready(s1_arready), .araddr(s1_araddr),
		.rvalid(s1_rvalid), .rready(s1_rready), .rdata(s1_rdata), .rresp(s1_rresp),
		.req(req1), .gnt(gnt1), .rsp(rsp1)
	);

	mem_arbiter u_arb (
		.clk_a(clk_a), .rst_n(rst_n),
		.req0(req0), .req1(req1), .gnt0(gnt0), .gnt1(gnt1),
		.rsp0(rsp0), .rsp1(rsp1),
		.ram_req(ram_a_req), .ram_rdata(ram_a_rdata)
	);

	dpsram u_ram (
		.clk_a(clk_a), .rst_n(rst_n),
		.a_req(ram_a_req), .a_rdata(ram_a_rdata),
		.b_req(rd_req), .b_rdata(rd_data), .b_valid(rd_valid)
	);

endmodule

`default_nettype wire

/* tb_clkgen.sv */
/*
 * testbench clock, 8 ns period
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
	output logic clk_a
);
	initial clk_a = 1'b0;
	always #4 clk_a = ~clk_a;  // 125 MHz
endmodule

`default_nettype wire

/* tb_shared_sram.sv */
/*
 * testbench for the shared scratchpad
 * both AXI4-Lite hosts and the readout port against a shadow memory
 */
`timescale 1ns/1ps
`default_nettype none

module tb_shared_sram;
	import sram_pkg::*;

	localparam int MAX_CYCLES = 4000;  // all tests with ample margin
	localparam int ALONE_LAT  = 4;     // handshake edge to response without contention
	localparam int SLACK      = 2;     // allowed loss to the other host

	logic        clk_a, rst_n;
	logic        awvalid [2], wvalid [2], bready [2], arvalid [2], rready [2];
	logic        awready [2], wready [2], bvalid [2], arready [2], rvalid [2];
	axi_addr_t   awaddr [2], araddr [2];
	data_t       wdata [2], rdata [2];
	strb_t       wstrb [2];
	resp_t       bresp [2], rresp [2];
	rd_req_t     rd_req;
	data_t       rd_data;
	logic        rd_valid;
	data_t       shadow [0:(2**MEM_AW)-1];  // what the RAM should hold
	logic [15:0] lfsr_q [2];               // one stream per host
	int          val_errs = 0;
	int          proto_errs = 0;
	int          cycles = 0;

	tb_clkgen u_clk (.clk_a(clk_a));

	shared_sram_top DUT (
		.clk_a(clk_a), .rst_n(rst_n),
		.s0_awvalid(awvalid[0]), .s0_awready(awready[0]), .s0_awaddr(awaddr[0]),
		.s0_wvalid(wvalid[0]), .s0_wready(wready[0]), .s0_wdata(wdata[0]), .s0_wstrb(wstrb[0]),
		.s0_bvalid(bvalid[0]), .s0_bready(bready[0]), .s0_bresp(bresp[0]),
		.s0_arvalid(arvalid[0]), .s0_arready(arready[0]), .s0_araddr(araddr[0]),
		.s0_rvalid(rvalid[0]), .s0_rready(rready[0]), .s0_rdata(rdata[0]), .s0_rresp(rresp[0]),
		.s1_awvalid(awvalid[1]), .s1_awready(awready[1]), .s1_awaddr(awaddr[1]),
		.s1_wvalid(wvalid[1]), .s1_wready(wready[1]), .s1_wdata(wdata[1]), .s1_wstrb(wstrb[1]),
		.s1_bvalid(bvalid[1]), .s1_bready(bready[1]), .s1_bresp(bresp[1]),
		.s1_arvalid(arvalid[1]), .s1_arready(arready[1]), .s1_araddr(araddr[1]),
		.s1_rvalid(rvalid[1]), .s1_rready(rready[1]), .s1_rdata(rdata[1]), .s1_rresp(rresp[1]),
		.rd_req(rd_req), .rd_data(rd_data), .rd_valid(rd_valid)
	);

	// galois LFSR on x^16+x^14+x^13+x^11+1 stepped once per bit taken
	function automatic logic [31:0] rand_bits(input int p, input int n);
		logic [31:0] r;
		logic        b;
		r = '0;
		for (int i = 0; i < n; i++) begin
			b = lfsr_q[p][0];
			lfsr_q[p] = {1'b0, lfsr_q[p][15:1]} ^ (b ? 16'hB400 : 16'h0000);
			r = {r[30:0], b};
		end
		return r;
	endfunction

	task automatic check_val(input string name, input data_t exp, input data_t got);
		assert (got === exp) else begin
			val_errs++;
			$display("ERR %s expected %h actual %h", name, exp, got);
		end
	endtask

	// wait for B or R, keep ready low for stall cycles, then accept
	task automatic take_resp(input int p, input logic is_wr, input int stall,
			input string name, output resp_t resp, output data_t data);
		int lat;
		lat = 0;
		do begin
			@(negedge clk_a);
			lat++;
		end while (!(is_wr ? bvalid[p] : rvalid[p]));
		resp = is_wr ? bresp[p] : rresp[p];
		data = rdata[p];
		assert (lat <= ALONE_LAT + SLACK) else begin
			proto_errs++;
			$display("%s: host %0d waited %0d cycles for its response, arbitration unfair",
				name, p, lat);
		end
		repeat (stall) @(negedge clk_a);  // the hold assertions watch the held response
		@(posedge clk_a);
		#1;
		bready[p] = is_wr;
		rready[p] = !is_wr;
		@(posedge clk_a);
		#1;
		bready[p] = 1'b0;
		rready[p] = 1'b0;
	endtask

	task automatic axi_write(input int p, input axi_addr_t addr, input data_t data,
			input strb_t strb, input int stall, input string name);
		word_addr_t w;
		resp_t      exp_resp, got_resp;
		data_t      unused;
		w        = addr[MEM_AW+1:2];
		exp_resp = (addr < 16'h1000) ? RESP_OKAY : RESP_SLVERR;  // 4 KiB window
		awaddr[p]  = addr;
		wdata[p]   = data;
		wstrb[p]   = strb;
		awvalid[p] = 1'b1;
		wvalid[p]  = 1'b1;
		@(negedge clk_a);
		while (!(awready[p] && wready[p])) @(negedge clk_a);
		@(posedge clk_a);
		#1;
		awvalid[p] = 1'b0;
		wvalid[p]  = 1'b0;
		take_resp(p, 1'b1, stall, name, got_resp, unused);
		check_val({name, " bresp"}, data_t'(exp_resp), data_t'(got_resp));
		if (exp_resp == RESP_OKAY)
			for (int i = 0; i < STRB_W; i++)
				if (strb[i]) shadow[w][i*8 +: 8] = data[i*8 +: 8];  // visible from bvalid on
	endtask

	task automatic axi_read(input int p, input axi_addr_t addr, input int stall,
			input string name);
		word_addr_t w;
		resp_t      exp_resp, got_resp;
		data_t      got;
		w        = addr[MEM_AW+1:2];
		exp_resp = (addr < 16'h1000) ? RESP_OKAY : RESP_SLVERR;
		araddr[p]  = addr;
		arvalid[p] = 1'b1;
		@(negedge clk_a);
		while (!arready[p]) @(negedge clk_a);
		@(posedge clk_a);
		#1 arvalid[p] = 1'b0;
		take_resp(p, 1'b0, stall, name, got_resp, got);
		check_val({name, " rresp"}, data_t'(exp_resp), data_t'(got_resp));
		if (exp_resp == RESP_OKAY) check_val({name, " rdata"}, shadow[w], got);
	endtask

	task automatic readout(input word_addr_t w, input string name);
		rd_req.addr = w;
		rd_req.en   = 1'b1;
		@(posedge clk_a);
		#1 rd_req.en = 1'b0;
		repeat (2) @(negedge clk_a);  // request edge plus the RAM stage
		check_val({name, " rd_data"}, shadow[w], rd_data);
		@(posedge clk_a);
		#1;
	endtask

	// each host on its own half of words 0..63, so the shadow stays exact
	task automatic rand_traffic(input int p);
		logic [31:0] r;
		axi_addr_t   a;
		data_t       d;
		strb_t       s;
		int          stall;
		for (int n = 0; n < 100; n++) begin
			r     = rand_bits(p, 5);
			a     = {8'h00, r[4:0], p[0], 2'b00};
			d     = rand_bits(p, 32);
			r     = rand_bits(p, 4);
			s     = (r[3:0] == 4'h0) ? 4'hF : r[3:0];  // always some lane
			r     = rand_bits(p, 3);
			stall = int'(r[1:0]);
			if (r[2]) axi_write(p, a, d, s, stall, "random write");
			else      axi_read(p, a, stall, "random read");
		end
	endtask

	for (genvar g = 0; g < 2; g++) begin : g_hold
		// held until accepted, gone right after
		b_hold: assert property (@(posedge clk_a) disable iff (!rst_n)
			bvalid[g] |=> ($past(bready[g]) ? !bvalid[g] : bvalid[g] && $stable(bresp[g])))
			else begin
				proto_errs++;
				$display("host %0d write response lost, changed or repeated", g);
			end
		r_hold: assert property (@(posedge clk_a) disable iff (!rst_n)
			rvalid[g] |=> ($past(rready[g]) ? !rvalid[g] :
				rvalid[g] && $stable(rresp[g]) && $stable(rdata[g])))
			else begin
				proto_errs++;
				$display("host %0d read response lost, changed or repeated", g);
			end
	end

	rd_fixed_lat: assert property (@(posedge clk_a) disable iff (!rst_n)
		rd_valid == $past(rd_req.en, 2))
		else begin
			proto_errs++;
			$display("rd_valid did not follow rd_req.en by exactly 2 cycles");
		end

	always @(posedge clk_a) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("run stopped after %0d cycles, a handshake never completed", cycles);
			$display("Test FAILED");
			$finish;
		end
	end

	initial begin
		rst_n  = 1'b0;
		rd_req = '0;
		for (int p = 0; p < 2; p++) begin
			awvalid[p] = 1'b0;
			wvalid[p]  = 1'b0;
			bready[p]  = 1'b0;
			arvalid[p] = 1'b0;
			rready[p]  = 1'b0;
			awaddr[p]  = '0;
			araddr[p]  = '0;
			wdata[p]   = '0;
			wstrb[p]   = '0;
			lfsr_q[p]  = 16'd45552;
		end
		void'(rand_bits(1, 7));  // host 1 runs offset from host 0
		repeat (5) @(posedge clk_a);
		#1 rst_n = 1'b1;
		@(posedge clk_a);
		#1;
		for (int i = 0; i < 64; i++)  // words used by random traffic
			axi_write(i % 2, axi_addr_t'(i * 4), rand_bits(0, 32), 4'hF, 0, "fill");
		axi_write(0, 16'h0010, 32'hA5A5_0F0F, 4'hF, 0, "wr_rd host0");
		axi_read(0, 16'h0010, 0, "wr_rd host0");
		axi_write(1, 16'h0FFC, 32'h1234_5678, 4'hF, 0, "wr_rd host1");
		axi_read(1, 16'h0FFC, 0, "wr_rd host1");
		axi_write(0, 16'h0010, 32'hDEAD_BEEF, 4'b0101, 0, "strobe");
		axi_write(1, 16'h0010, 32'hCAFE_F00D, 4'b1000, 1, "strobe");
		axi_read(0, 16'h0010, 0, "strobe");
		axi_write(0, 16'h0204, 32'h0BAD_CAFE, 4'hF, 0, "cross");
		axi_read(1, 16'h0204, 0, "cross");
		readout(10'h081, "readout");
		readout(10'h3FF, "readout");
		axi_write(1, 16'h0300, 32'h7777_7777, 4'hF, 0, "out of range");
		axi_write(0, 16'h1300, 32'h0000_0000, 4'hF, 2, "out of range");  // alias of 0x0C0
		axi_read(1, 16'hF300, 3, "out of range");
		axi_read(0, 16'h0300, 0, "out of range");
		fork
			rand_traffic(0);
			rand_traffic(1);
		join
		$display("value errors %0d, protocol errors %0d", val_errs, proto_errs);
		if (val_errs == 0 && proto_errs == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* files.f */
sram_pkg.sv
dpsram.sv
axil_mem_port.sv
mem_arbiter.sv
shared_sram_top.sv
tb_clkgen.sv
tb_shared_sram.sv

/* Makefile */
# Verilator build for the shared scratchpad memory

TOP := tb_shared_sram

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f files.f --top-module $(TOP)

# pass only when the run prints the pass line
sim:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir
